// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

TOP = ic_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f icache.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== icache.f ====
+incdir+include
logic/ic_pkg.sv
logic/ic_way.sv
logic/ic_way_select.sv
logic/ic_ctrl.sv
logic/ic_top.sv
verif/ic_sva.sv
verif/ic_tb.sv

// ==== include/ic_defs.svh ====
`ifndef IC_DEFS_SVH
`define IC_DEFS_SVH

// cache geometry
`define IC_WAYS 2
`define IC_SETS 64
`define IC_INDEX_W 6

// fetch port widths
`define IC_ADDR_W 32
`define IC_DATA_W 32

// address less index and byte offset
`define IC_TAG_W 24

// saturating age counter per way and set
`define IC_AGE_W 3

`endif

// ==== logic/ic_ctrl.sv ====
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_req,
    input  ic_pkg::fetch_addr_t    i_addr,
    input  logic                   i_inv,
    input  logic                   i_hit,
    input  logic [`IC_DATA_W-1:0]  i_hit_data,
    input  logic [`IC_WAYS-1:0]    i_victim,
    input  logic                   i_mem_valid,
    input  logic [`IC_DATA_W-1:0]  i_mem_data,
    output logic [`IC_INDEX_W-1:0] o_index,
    output logic [`IC_TAG_W-1:0]   o_tag,
    output ic_pkg::refill_t        o_refill,
    output logic [`IC_WAYS-1:0]    o_fill_way,
    output logic                   o_inv,
    output logic                   o_touch,
    output logic [`IC_WAYS-1:0]    o_touch_way,
    output logic                   o_mem_req,
    output logic [`IC_ADDR_W-1:0]  o_mem_addr,
    output ic_pkg::fetch_rsp_t     o_rsp
);

    import ic_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL,
        ST_RESP
    } state_t;

    state_t                state_q;
    fetch_addr_t           addr_q;
    logic [`IC_WAYS-1:0]   fill_way_q;
    logic [`IC_DATA_W-1:0] rsp_data_q;
    logic                  rsp_valid_q;
    logic                  mem_req_q;
    logic                  wait_q;

    logic accept;
    logic fill_now;

    // invalidate wins over a request in the same idle cycle
    assign o_inv    = (state_q == ST_IDLE) && i_inv;
    assign accept   = (state_q == ST_IDLE) && i_req && !i_inv;
    assign fill_now = (state_q == ST_REFILL) && wait_q && i_mem_valid;

    // idle reads straight from the port so the array read starts on accept
    assign o_index = (state_q == ST_IDLE) ? i_addr.index : addr_q.index;
    assign o_tag   = (state_q == ST_IDLE) ? i_addr.tag : addr_q.tag;

    always_comb begin
        o_refill.wr    = fill_now;
        o_refill.index = addr_q.index;
        o_refill.tag   = addr_q.tag;
        o_refill.data  = i_mem_data;
    end

    assign o_fill_way  = fill_way_q;
    assign o_touch     = ((state_q == ST_LOOKUP) && i_hit) || fill_now;
    assign o_touch_way = (state_q == ST_LOOKUP) ? i_victim : fill_way_q;

    assign o_mem_req  = mem_req_q;
    assign o_mem_addr = {addr_q.tag, addr_q.index, 2'b00};

    assign o_rsp.valid = rsp_valid_q;
    assign o_rsp.data  = rsp_data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= ST_IDLE;
            mem_req_q   <= 1'b0;
            wait_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            mem_req_q   <= 1'b0;
            rsp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state_q <= i_hit ? ST_RESP : ST_REFILL;
                end
                ST_REFILL: begin
                    // one request per miss, then wait for the word
                    if (!wait_q) begin
                        mem_req_q <= 1'b1;
                        wait_q    <= 1'b1;
                    end else if (i_mem_valid) begin
                        wait_q  <= 1'b0;
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    rsp_valid_q <= 1'b1;
                    state_q     <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // payload captured along the way
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_addr;
        end
        if ((state_q == ST_LOOKUP) && i_hit) begin
            rsp_data_q <= i_hit_data;
        end
        if ((state_q == ST_LOOKUP) && !i_hit) begin
            fill_way_q <= i_victim;
        end
        // forward the refill word
        if (fill_now) begin
            rsp_data_q <= i_mem_data;
        end
    end

endmodule

// ==== logic/ic_pkg.sv ====
`include "ic_defs.svh"

package ic_pkg;

    // fetch address split into its cache fields
    typedef struct packed {
        logic [`IC_TAG_W-1:0]   tag;
        logic [`IC_INDEX_W-1:0] index;
        logic [1:0]             offset;
    } fetch_addr_t;

    // one-cycle response to the fetch port
    typedef struct packed {
        logic                  valid;
        logic [`IC_DATA_W-1:0] data;
    } fetch_rsp_t;

    // write command broadcast to all ways
    typedef struct packed {
        logic                   wr;
        logic [`IC_INDEX_W-1:0] index;
        logic [`IC_TAG_W-1:0]   tag;
        logic [`IC_DATA_W-1:0]  data;
    } refill_t;

    // lookup result of one way
    typedef struct packed {
        logic                  hit;
        logic                  valid;
        logic [`IC_DATA_W-1:0] data;
    } way_look_t;

endpackage

// ==== logic/ic_top.sv ====
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_req,
    input  ic_pkg::fetch_addr_t   i_addr,
    input  logic                  i_inv,
    output ic_pkg::fetch_rsp_t    o_rsp,
    output logic                  o_mem_req,
    output logic [`IC_ADDR_W-1:0] o_mem_addr,
    input  logic                  i_mem_valid,
    input  logic [`IC_DATA_W-1:0] i_mem_data
);

    import ic_pkg::*;

    logic [`IC_INDEX_W-1:0]         index;
    logic [`IC_TAG_W-1:0]           tag;
    refill_t                        refill;
    logic [`IC_WAYS-1:0]            fill_way;
    logic                           inv;
    logic                           touch;
    logic [`IC_WAYS-1:0]            touch_way;
    way_look_t [`IC_WAYS-1:0]       looks;
    logic                           hit;
    logic [`IC_DATA_W-1:0]          hit_data;
    logic [`IC_WAYS-1:0]            victim;

    ic_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_req),
        .i_addr      (i_addr),
        .i_inv       (i_inv),
        .i_hit       (hit),
        .i_hit_data  (hit_data),
        .i_victim    (victim),
        .i_mem_valid (i_mem_valid),
        .i_mem_data  (i_mem_data),
        .o_index     (index),
        .o_tag       (tag),
        .o_refill    (refill),
        .o_fill_way  (fill_way),
        .o_inv       (inv),
        .o_touch     (touch),
        .o_touch_way (touch_way),
        .o_mem_req   (o_mem_req),
        .o_mem_addr  (o_mem_addr),
        .o_rsp       (o_rsp)
    );

    // all ways see the same lookup and refill, each with its own select
    for (genvar w = 0; w < `IC_WAYS; w++) begin : g_way
        ic_way u_way (
            .clk       (clk),
            .rst       (rst),
            .i_index   (index),
            .i_tag     (tag),
            .i_refill  (refill),
            .i_inv     (inv),
            .i_way_sel (fill_way[w]),
            .o_look    (looks[w])
        );
    end

    ic_way_select u_way_select (
        .clk         (clk),
        .rst         (rst),
        .i_looks     (looks),
        .i_index     (index),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .o_hit       (hit),
        .o_hit_data  (hit_data),
        .o_victim    (victim)
    );

endmodule

// ==== logic/ic_way.sv ====
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_way (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`IC_INDEX_W-1:0] i_index,
    input  logic [`IC_TAG_W-1:0]   i_tag,
    input  ic_pkg::refill_t        i_refill,
    input  logic                   i_inv,
    input  logic                   i_way_sel,
    output ic_pkg::way_look_t      o_look
);

    logic [`IC_TAG_W-1:0]  tag_mem  [`IC_SETS];
    logic [`IC_DATA_W-1:0] data_mem [`IC_SETS];
    logic [`IC_SETS-1:0]   valid_q;

    logic                  fill;
    logic [`IC_TAG_W-1:0]  rd_tag;
    logic [`IC_DATA_W-1:0] rd_data;
    logic                  rd_valid;
    logic [`IC_TAG_W-1:0]  look_tag;

    // this way is the fill target
    assign fill = i_refill.wr && i_way_sel;

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[i_refill.index]  <= i_refill.tag;
            data_mem[i_refill.index] <= i_refill.data;
        end
    end

    // synchronous read, tag held alongside for the compare
    always_ff @(posedge clk) begin
        rd_tag   <= tag_mem[i_index];
        rd_data  <= data_mem[i_index];
        look_tag <= i_tag;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            // invalidate only arrives while idle, never with a fill
            if (i_inv) begin
                valid_q <= '0;
            end else if (fill) begin
                valid_q[i_refill.index] <= 1'b1;
            end
            rd_valid <= valid_q[i_index];
        end
    end

    // tag compare on the registered read
    assign o_look.hit   = rd_valid && (rd_tag == look_tag);
    assign o_look.valid = rd_valid;
    assign o_look.data  = rd_data;

endmodule

// ==== logic/ic_way_select.sv ====
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_way_select (
    input  logic                                  clk,
    input  logic                                  rst,
    input  ic_pkg::way_look_t [`IC_WAYS-1:0]      i_looks,
    input  logic [`IC_INDEX_W-1:0]                i_index,
    input  logic                                  i_touch,
    input  logic [`IC_WAYS-1:0]                   i_touch_way,
    output logic                                  o_hit,
    output logic [`IC_DATA_W-1:0]                 o_hit_data,
    output logic [`IC_WAYS-1:0]                   o_victim
);

    localparam logic [`IC_AGE_W-1:0] AGE_MAX = '1;

    logic [`IC_AGE_W-1:0] age_q [`IC_SETS][`IC_WAYS];

    logic [`IC_WAYS-1:0] hit_vec;
    logic [`IC_WAYS-1:0] repl_vec;
    logic                any_inv;
    int                  inv_way;
    int                  old_way;

    // at most one way can hit, so an or of masked data is enough
    always_comb begin
        hit_vec    = '0;
        o_hit_data = '0;
        for (int w = 0; w < `IC_WAYS; w++) begin
            hit_vec[w] = i_looks[w].hit;
            if (i_looks[w].hit) begin
                o_hit_data = o_hit_data | i_looks[w].data;
            end
        end
    end

    assign o_hit = |hit_vec;

    // replacement choice for the looked-up set
    always_comb begin
        any_inv = 1'b0;
        inv_way = 0;
        old_way = 0;
        // walk downwards so the lowest invalid way wins
        for (int w = `IC_WAYS - 1; w >= 0; w--) begin
            if (!i_looks[w].valid) begin
                any_inv = 1'b1;
                inv_way = w;
            end
        end
        // strict compare keeps the lowest index on a tie
        for (int w = 1; w < `IC_WAYS; w++) begin
            if (age_q[i_index][w] > age_q[i_index][old_way]) begin
                old_way = w;
            end
        end
        repl_vec = '0;
        repl_vec[any_inv ? inv_way : old_way] = 1'b1;
    end

    // hit way on a hit, so the controller can touch it; else the victim
    assign o_victim = o_hit ? hit_vec : repl_vec;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `IC_SETS; s++) begin
                for (int w = 0; w < `IC_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (i_touch) begin
            // touched way restarts, the others grow old
            for (int w = 0; w < `IC_WAYS; w++) begin
                if (i_touch_way[w]) begin
                    age_q[i_index][w] <= '0;
                end else if (age_q[i_index][w] != AGE_MAX) begin
                    age_q[i_index][w] <= age_q[i_index][w] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verif/ic_sva.sv ====
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_sva (
    input logic               clk,
    input logic               rst,
    input logic               i_req,
    input logic               i_inv,
    input ic_pkg::fetch_rsp_t o_rsp,
    input logic               o_mem_req,
    input logic               i_mem_valid
);

    logic pending_q;
    logic refill_q;
    logic accept;

    // taken when nothing is in flight or the last fetch answers now
    assign accept = i_req && !i_inv && (!pending_q || o_rsp.valid);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending_q <= 1'b0;
            refill_q  <= 1'b0;
        end else begin
            if (accept) begin
                pending_q <= 1'b1;
            end else if (o_rsp.valid) begin
                pending_q <= 1'b0;
            end
            if (o_mem_req) begin
                refill_q <= 1'b1;
            end else if (i_mem_valid) begin
                refill_q <= 1'b0;
            end
        end
    end

    a_rsp_pending: assert property (@(posedge clk) disable iff (!rst)
        o_rsp.valid |-> pending_q)
        else $error("fetch response without a pending request");

    a_one_refill: assert property (@(posedge clk) disable iff (!rst)
        o_mem_req |-> !refill_q)
        else $error("memory request while a refill is outstanding");

    // two quiet cycles, then the hit response or the refill request
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst)
        accept |=> (!o_rsp.valid && !o_mem_req) ##1 (!o_rsp.valid && !o_mem_req)
        ##1 (o_rsp.valid || o_mem_req))
        else $error("hit response not 2 cycles after the request");

endmodule

bind ic_top ic_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .i_req       (i_req),
    .i_inv       (i_inv),
    .o_rsp       (o_rsp),
    .o_mem_req   (o_mem_req),
    .i_mem_valid (i_mem_valid)
);

// ==== verif/ic_tb.sv ====
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_tb;

    import ic_pkg::*;

    localparam int RSP_TIMEOUT = 100;
    localparam int AGE_TOP     = (1 << `IC_AGE_W) - 1;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  i_req;
    fetch_addr_t           i_addr;
    logic                  i_inv;
    fetch_rsp_t            o_rsp;
    logic                  o_mem_req;
    logic [`IC_ADDR_W-1:0] o_mem_addr;
    logic                  i_mem_valid = 1'b0;
    logic [`IC_DATA_W-1:0] i_mem_data = '0;
    logic [2:0]            mem_cnt;
    logic [`IC_ADDR_W-1:0] mem_addr_q;

    // expected tags, valid bits and ages per set and way
    logic [`IC_TAG_W-1:0]  ref_tag [`IC_SETS][`IC_WAYS];
    bit                    ref_valid [`IC_SETS][`IC_WAYS] = '{default: 1'b0};
    int                    ref_age [`IC_SETS][`IC_WAYS] = '{default: 0};
    int                    checks = 0;
    int                    errors = 0;
    int                    tests = 0;

    ic_top u_ic_top (.*);

    always #5 clk = ~clk;

    // memory answers each request after 1 to 5 cycles
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_cnt     <= '0;
            i_mem_valid <= 1'b0;
        end else begin
            i_mem_valid <= 1'b0;
            if (o_mem_req) begin
                mem_cnt    <= 3'($urandom_range(5, 1));
                mem_addr_q <= o_mem_addr;
            end else if (mem_cnt != 3'd0) begin
                mem_cnt <= mem_cnt - 3'd1;
                if (mem_cnt == 3'd1) begin
                    i_mem_valid <= 1'b1;
                    i_mem_data  <= mem_addr_q ^ 32'h5a5a_0000;
                end
            end
        end
    end

    // reference of the age and victim rules
    // returns 1 when the fetch should miss
    function automatic bit predict_access(input logic [`IC_ADDR_W-1:0] addr);
        logic [`IC_INDEX_W-1:0] set_i;
        logic [`IC_TAG_W-1:0]   tag;
        int                     way;
        bit                     miss;
        set_i = addr[`IC_INDEX_W+1:2];
        tag   = addr[`IC_ADDR_W-1:`IC_INDEX_W+2];
        way   = -1;
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (ref_valid[set_i][w] && ref_tag[set_i][w] == tag) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            for (int w = `IC_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[set_i][w]) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = 0;
                for (int w = 1; w < `IC_WAYS; w++) begin
                    if (ref_age[set_i][w] > ref_age[set_i][way]) begin
                        way = w;
                    end
                end
            end
            ref_valid[set_i][way] = 1'b1;
            ref_tag[set_i][way]   = tag;
        end
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (w == way) begin
                ref_age[set_i][w] = 0;
            end else if (ref_age[set_i][w] < AGE_TOP) begin
                ref_age[set_i][w]++;
            end
        end
        return miss;
    endfunction

    task automatic check_value(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", tests, name, errors - err_before);
        end
    endtask

    // one fetch, checked against the memory function and the reference model
    task automatic fetch(input logic [`IC_ADDR_W-1:0] addr, output bit missed);
        logic [`IC_ADDR_W-1:0] word;
        logic [`IC_DATA_W-1:0] data;
        bit                    seen;
        bit                    exp_miss;
        int                    reqs;
        int                    lat;
        word     = {addr[`IC_ADDR_W-1:2], 2'b00};
        exp_miss = predict_access(addr);
        seen     = 1'b0;
        reqs     = 0;
        lat      = 0;
        data     = '0;
        @(posedge clk);
        i_req  <= 1'b1;
        i_addr <= addr;
        @(posedge clk);
        i_req  <= 1'b0;
        while (!seen && lat < RSP_TIMEOUT) begin
            @(negedge clk);
            if (o_mem_req) begin
                reqs++;
                check_value(o_mem_addr == word,
                    $sformatf("refill address %h for fetch %h", o_mem_addr, addr));
            end
            if (o_rsp.valid) begin
                seen = 1'b1;
                data = o_rsp.data;
            end else begin
                @(posedge clk);
                lat++;
            end
        end
        missed = (reqs != 0);
        if (!seen) begin
            $display("timeout: no response to the fetch of %h after %0d cycles", addr, lat);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            check_value(data == (word ^ 32'h5a5a_0000),
                $sformatf("fetch %h returned %h", addr, data));
            check_value(reqs == (exp_miss ? 1 : 0),
                $sformatf("fetch %h issued %0d refills, expected miss %0b", addr, reqs, exp_miss));
            if (!exp_miss) begin
                check_value(lat == 2, $sformatf("hit on %h took %0d cycles", addr, lat));
            end
        end
    endtask

    initial begin
        logic [`IC_ADDR_W-1:0] a;
        logic [`IC_ADDR_W-1:0] p;
        logic [`IC_ADDR_W-1:0] q;
        logic [`IC_ADDR_W-1:0] r;
        bit                    miss;
        int                    mark;
        int unsigned           seed;
        seed   = $urandom(32'h7b26_f899);
        rst    = 1'b0;
        i_req  = 1'b0;
        i_addr = '0;
        i_inv  = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        mark = errors;
        repeat (6) begin
            @(negedge clk);
            check_value(!o_rsp.valid && !o_mem_req, "response or refill right after reset");
        end
        report_test("quiet after reset", mark);
        a    = {24'h00_0123, 6'd5, 2'b10};
        mark = errors;
        fetch(a, miss);
        check_value(miss, "first fetch did not miss");
        report_test("first fetch refills", mark);
        mark = errors;
        fetch(a, miss);
        check_value(!miss, "repeated fetch missed");
        report_test("repeated fetch hits", mark);
        // A, B, A, C in set 12 leaves A cached and B evicted
        p    = {24'h00_0a01, 6'd12, 2'b00};
        q    = {24'h00_0a02, 6'd12, 2'b00};
        r    = {24'h00_0a03, 6'd12, 2'b00};
        mark = errors;
        fetch(p, miss);
        fetch(q, miss);
        fetch(p, miss);
        fetch(r, miss);
        fetch(p, miss);
        check_value(!miss, "most recent way was replaced");
        fetch(q, miss);
        check_value(miss, "oldest way was not replaced");
        report_test("replacement", mark);
        mark = errors;
        @(posedge clk);
        i_inv <= 1'b1;
        @(posedge clk);
        i_inv <= 1'b0;
        ref_valid = '{default: 1'b0};
        fetch(a, miss);
        check_value(miss, "fetch after invalidate did not miss");
        report_test("invalidate", mark);
        mark = errors;
        for (int i = 0; i < 200; i++) begin
            p = {24'h00_0b00 + 24'($urandom_range(2, 0)),
                 6'(4 * $urandom_range(3, 0) + 20), 2'($urandom)};
            fetch(p, miss);
            repeat ($urandom_range(3, 0)) @(posedge clk);
        end
        report_test("random fetches", mark);
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
